// File: y86_core.f
common/y86_isa_pkg.sv
common/y86_core_pkg.sv
common/wb_if.sv
execute/execute.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/core_ctrl.sv
verilog/y86_core.sv
sim/wb_mem_model.sv
sim/tb_y86_core.sv

// File: Bender.yml
package:
  name: y86_core

sources:
  - common/y86_isa_pkg.sv
  - common/y86_core_pkg.sv
  - common/wb_if.sv
  - execute/execute.sv
  - verilog/fetch_unit.sv
  - verilog/regfile.sv
  - verilog/core_ctrl.sv
  - verilog/y86_core.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_y86_core.sv

// File: sim/tb_y86_core.sv
`timescale 1ns/100ps

module tb_y86_core;

    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 5;
    localparam int N_VEC       = 11;
    localparam int N_EXTRA     = 3;   // load/store, bad icode, bad address
    localparam int PROG_CYCLES = 400;
    localparam int RUN_LIMIT   = 300;
    localparam int MEM_WORDS   = 256;

    localparam logic [3:0] RAX = 4'h0;
    localparam logic [3:0] RCX = 4'h1;
    localparam logic [3:0] RDX = 4'h2;
    localparam logic [3:0] RBX = 4'h3;
    localparam logic [3:0] RSI = 4'h6;

    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  cond;
        logic [63:0] a;
        logic [63:0] b;
    } vec_t;

    logic        clk   = 1'b0;
    logic        rst_n = 1'b0;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, halted;
    logic [15:0] wb_adr;
    logic [63:0] wb_dat_w, wb_dat_r;
    logic [1:0]  stat;

    vec_t        vectors [0:N_VEC-1];
    logic [63:0] image [0:MEM_WORDS-1];
    logic [15:0] wr_ptr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    y86_core u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .halted_o(halted), .stat_o(stat)
    );

    wb_mem_model #(.DEPTH(MEM_WORDS)) u_mem (
        .clk_i(clk), .rst_n_i(rst_n), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
        .adr_i(wb_adr), .dat_i(wb_dat_w), .dat_o(wb_dat_r), .ack_o(wb_ack)
    );

    function automatic logic [63:0] fill_word(input int idx);
        return {16'hf00d, idx[15:0], 16'h0bad, ~idx[15:0]};
    endfunction

    function automatic logic [63:0] mem_word(input logic [15:0] addr);
        return u_mem.mem[addr[10:3]];
    endfunction

    function automatic logic [63:0] alu_result(input logic [3:0] op, input logic [63:0] va,
                                               input logic [63:0] vb);
        case (op)
            y86_isa_pkg::ALU_SUB: return vb - va;
            y86_isa_pkg::ALU_AND: return va & vb;
            y86_isa_pkg::ALU_XOR: return va ^ vb;
            default:              return va + vb;
        endcase
    endfunction

    function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] op,
                                        input logic [63:0] va, input logic [63:0] vb);
        logic [64:0] wide;
        logic [63:0] r;
        logic        zf, sf, of;
        r    = alu_result(op, va, vb);
        wide = 65'd0;
        if (op == y86_isa_pkg::ALU_ADD) begin
            wide = {va[63], va} + {vb[63], vb};
        end else if (op == y86_isa_pkg::ALU_SUB) begin
            wide = {vb[63], vb} - {va[63], va};
        end
        zf = (r == 64'd0);
        sf = r[63];
        of = wide[64] ^ wide[63]; // result left the signed range
        case (cond)
            y86_isa_pkg::C_YES: return 1'b1;
            y86_isa_pkg::C_LE:  return (sf ^ of) | zf;
            y86_isa_pkg::C_L:   return sf ^ of;
            y86_isa_pkg::C_E:   return zf;
            y86_isa_pkg::C_NE:  return !zf;
            y86_isa_pkg::C_GE:  return !(sf ^ of);
            y86_isa_pkg::C_G:   return !(sf ^ of) && !zf;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic clear_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = fill_word(i);
        end
        wr_ptr = 16'd0;
    endtask

    task automatic emit_byte(input logic [7:0] b);
        logic [63:0] w;
        w = image[wr_ptr[10:3]];
        w[8*wr_ptr[2:0] +: 8] = b; // little endian lane
        image[wr_ptr[10:3]] = w;
        wr_ptr = wr_ptr + 16'd1;
    endtask

    task automatic emit_quad(input logic [63:0] v);
        for (int i = 0; i < 8; i++) begin
            emit_byte(v[8*i +: 8]);
        end
    endtask

    task automatic emit_irmovq(input logic [63:0] v, input logic [3:0] rb);
        emit_byte({y86_isa_pkg::I_IRMOVQ, 4'h0});
        emit_byte({y86_isa_pkg::R_NONE, rb});
        emit_quad(v);
    endtask

    task automatic emit_rmmovq(input logic [3:0] ra, input logic [3:0] rb,
                               input logic [63:0] d);
        emit_byte({y86_isa_pkg::I_RMMOVQ, 4'h0});
        emit_byte({ra, rb});
        emit_quad(d);
    endtask

    task automatic emit_mrmovq(input logic [3:0] ra, input logic [3:0] rb,
                               input logic [63:0] d);
        emit_byte({y86_isa_pkg::I_MRMOVQ, 4'h0});
        emit_byte({ra, rb});
        emit_quad(d);
    endtask

    task automatic emit_two(input logic [3:0] icode, input logic [3:0] fun,
                            input logic [3:0] ra, input logic [3:0] rb);
        emit_byte({icode, fun}); // OPq and cmovXX share this form
        emit_byte({ra, rb});
    endtask

    task automatic emit_jxx(input logic [3:0] cond, input logic [63:0] dest);
        emit_byte({y86_isa_pkg::I_JXX, cond});
        emit_quad(dest);
    endtask

    task automatic build_alu_program(input vec_t v);
        logic [15:0] target;
        clear_image();
        emit_irmovq(v.a, RAX);
        emit_irmovq(v.b, RBX);
        emit_two(y86_isa_pkg::I_OPQ, v.op, RBX, RAX);
        emit_rmmovq(RAX, y86_isa_pkg::R_NONE, 64'h200);
        emit_irmovq(64'd0, RCX);
        emit_two(y86_isa_pkg::I_RRMOVQ, v.cond, RBX, RCX);
        emit_rmmovq(RCX, y86_isa_pkg::R_NONE, 64'h208);
        target = wr_ptr + 16'd9 + 16'd21; // taken path follows the 21 byte fall-through
        emit_jxx(v.cond, {48'd0, target});
        emit_irmovq(64'd2, RDX);
        emit_rmmovq(RDX, y86_isa_pkg::R_NONE, 64'h210);
        emit_byte({y86_isa_pkg::I_HALT, 4'h0});
        emit_irmovq(64'd1, RDX);
        emit_rmmovq(RDX, y86_isa_pkg::R_NONE, 64'h210);
        emit_byte({y86_isa_pkg::I_HALT, 4'h0});
    endtask

    task automatic run_program();
        int n;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] <= image[i];
        end
        rst_n <= 1'b1;
        n = 0;
        while (!halted && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!halted) begin
            $display("core did not halt within %0d cycles", RUN_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "core hung");
        end
    endtask

    initial begin
        #((N_VEC + N_EXTRA) * PROG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all programs finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [63:0] exp_val;
        logic [63:0] rnd;
        logic        taken;

        void'($urandom(32'h5d8));
        vectors[0]  = {y86_isa_pkg::ALU_ADD, y86_isa_pkg::C_YES, 64'd5, 64'd7};
        vectors[1]  = {y86_isa_pkg::ALU_SUB, y86_isa_pkg::C_LE, 64'd3, 64'd3};
        vectors[2]  = {y86_isa_pkg::ALU_SUB, y86_isa_pkg::C_L, 64'd2, 64'd9};
        vectors[3]  = {y86_isa_pkg::ALU_AND, y86_isa_pkg::C_E, 64'hf0, 64'h0f};
        vectors[4]  = {y86_isa_pkg::ALU_XOR, y86_isa_pkg::C_NE, 64'h55, 64'h55};
        vectors[5]  = {y86_isa_pkg::ALU_ADD, y86_isa_pkg::C_GE, 64'h7fff_ffff_ffff_ffff, 64'd1};
        vectors[6]  = {y86_isa_pkg::ALU_SUB, y86_isa_pkg::C_G, 64'd10, 64'd3};
        vectors[7]  = {y86_isa_pkg::ALU_SUB, y86_isa_pkg::C_L, 64'h8000_0000_0000_0000, 64'd1};
        vectors[8]  = {y86_isa_pkg::ALU_ADD, y86_isa_pkg::C_G, -64'd5, 64'd2};
        vectors[9]  = {y86_isa_pkg::ALU_XOR, y86_isa_pkg::C_LE, 64'h1234, 64'h4321};
        vectors[10] = {y86_isa_pkg::ALU_AND, y86_isa_pkg::C_GE, -64'd1, -64'd8};

        for (int t = 0; t < N_VEC; t++) begin
            build_alu_program(vectors[t]);
            run_program();
            // OPq rbx, rax reads valA from rbx and valB from rax
            exp_val = alu_result(vectors[t].op, vectors[t].b, vectors[t].a);
            taken   = cond_holds(vectors[t].cond, vectors[t].op, vectors[t].b, vectors[t].a);
            check_value("stat_o", {62'd0, stat}, {62'd0, y86_isa_pkg::STAT_HLT});
            check_value("mem[0x200]", mem_word(16'h200), exp_val);
            check_value("mem[0x208]", mem_word(16'h208), taken ? vectors[t].b : 64'd0);
            check_value("mem[0x210]", mem_word(16'h210), taken ? 64'd1 : 64'd2);
        end

        // store, load back and store again
        rnd = {$urandom, $urandom};
        clear_image();
        emit_irmovq(rnd, RAX);
        emit_irmovq(64'h100, RBX);
        emit_rmmovq(RAX, RBX, 64'h100);
        emit_mrmovq(RSI, y86_isa_pkg::R_NONE, 64'h200);
        emit_rmmovq(RSI, RBX, 64'h118);
        emit_byte({y86_isa_pkg::I_HALT, 4'h0});
        run_program();
        check_value("stat_o", {62'd0, stat}, {62'd0, y86_isa_pkg::STAT_HLT});
        check_value("mem[0x200]", mem_word(16'h200), rnd);
        check_value("mem[0x218]", mem_word(16'h218), rnd);

        clear_image();
        emit_byte({y86_isa_pkg::I_NOP, 4'h0});
        emit_byte(8'hc0); // no such icode
        run_program();
        check_value("stat_o", {62'd0, stat}, {62'd0, y86_isa_pkg::STAT_INS});

        clear_image();
        emit_irmovq(rnd, RAX);
        emit_rmmovq(RAX, y86_isa_pkg::R_NONE, 64'h204);
        emit_byte({y86_isa_pkg::I_HALT, 4'h0});
        run_program();
        check_value("stat_o", {62'd0, stat}, {62'd0, y86_isa_pkg::STAT_ADR});
        check_value("mem[0x200]", mem_word(16'h200), fill_word(16'h200 >> 3));
        check_value("mem[0x208]", mem_word(16'h208), fill_word(16'h208 >> 3));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model #(
    parameter int DEPTH = 256
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [15:0] adr_i,
    input  logic [63:0] dat_i,
    output logic [63:0] dat_o,
    output logic        ack_o
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [63:0]      mem [0:DEPTH-1]; // loaded by the testbench
    logic [63:0]      rd_q   = '0;
    logic             ack_q  = 1'b0;
    logic [1:0]       wait_q = 2'd0;
    logic [IDX_W-1:0] idx;

    assign idx   = adr_i[3 +: IDX_W]; // whole words only
    assign dat_o = rd_q;
    assign ack_o = ack_q;

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            wait_q <= 2'($urandom_range(3, 0));
        end else begin
            ack_q <= 1'b0;
            if (cyc_i && stb_i && !ack_q) begin
                if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    ack_q  <= 1'b1;
                    wait_q <= 2'($urandom_range(3, 0)); // wait states for the next access
                    if (we_i) begin
                        mem[idx] <= dat_i;
                    end else begin
                        rd_q <= mem[idx];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/y86_core.sv
`timescale 1ns/100ps

module y86_core (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [y86_core_pkg::WORD_W-1:0] wb_dat_i,
    input  logic                             wb_ack_i,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [y86_core_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [y86_core_pkg::WORD_W-1:0] wb_dat_o,
    output logic                             halted_o,
    output logic [1:0]                       stat_o
);

    wb_if wb ();

    logic [3:0]                       icode, ifun, ra, rb;
    logic [3:0]                       srca, srcb, dst;
    logic [3:0]                       ex_icode, ex_ifun;
    logic [y86_core_pkg::WORD_W-1:0] valc, valp, vala, valb, vale, wr_data, pc;
    logic [y86_core_pkg::WORD_W-1:0] ex_vala, ex_valb, ex_valc;
    logic                             instr_ok, cnd, word0_ld, word1_ld, wr_en, exec_en;

    assign wb_cyc_o = wb.cyc;
    assign wb_stb_o = wb.stb;
    assign wb_we_o  = wb.we;
    assign wb_adr_o = wb.adr;
    assign wb_dat_o = wb.dat_w;
    assign wb.dat_r = wb_dat_i;
    assign wb.ack   = wb_ack_i;

    core_ctrl u_ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .wb(wb.master),
        .icode_i(icode), .ifun_i(ifun), .ra_i(ra), .rb_i(rb),
        .valc_i(valc), .valp_i(valp), .instr_ok_i(instr_ok),
        .vala_i(vala), .valb_i(valb), .vale_i(vale), .cnd_i(cnd),
        .word0_ld_o(word0_ld), .word1_ld_o(word1_ld), .pc_o(pc),
        .srca_o(srca), .srcb_o(srcb), .dst_o(dst), .wr_data_o(wr_data), .wr_en_o(wr_en),
        .exec_en_o(exec_en), .ex_icode_o(ex_icode), .ex_ifun_o(ex_ifun),
        .ex_vala_o(ex_vala), .ex_valb_o(ex_valb), .ex_valc_o(ex_valc),
        .halted_o(halted_o), .stat_o(stat_o)
    );

    fetch_unit u_fetch (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .word0_ld_i(word0_ld), .word1_ld_i(word1_ld),
        .wb_dat_i(wb_dat_i), .pc_i(pc),
        .icode_o(icode), .ifun_o(ifun), .ra_o(ra), .rb_o(rb),
        .valc_o(valc), .valp_o(valp), .instr_ok_o(instr_ok)
    );

    regfile u_regs (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .srca_i(srca), .srcb_i(srcb), .dst_i(dst),
        .wr_data_i(wr_data), .wr_en_i(wr_en), .vala_o(vala), .valb_o(valb)
    );

    execute u_exec (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .exec_en_i(exec_en),
        .icode_i(ex_icode), .ifun_i(ex_ifun),
        .vala_i(ex_vala), .valb_i(ex_valb), .valc_i(ex_valc),
        .vale_o(vale), .cnd_o(cnd)
    );

endmodule

// File: verilog/core_ctrl.sv
`timescale 1ns/100ps

module core_ctrl (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    wb_if.master                             wb,
    input  logic [3:0]                       icode_i,
    input  logic [3:0]                       ifun_i,
    input  logic [3:0]                       ra_i,
    input  logic [3:0]                       rb_i,
    input  logic [y86_core_pkg::WORD_W-1:0] valc_i,
    input  logic [y86_core_pkg::WORD_W-1:0] valp_i,
    input  logic                             instr_ok_i,
    input  logic [y86_core_pkg::WORD_W-1:0] vala_i,
    input  logic [y86_core_pkg::WORD_W-1:0] valb_i,
    input  logic [y86_core_pkg::WORD_W-1:0] vale_i,
    input  logic                             cnd_i,
    output logic                             word0_ld_o,
    output logic                             word1_ld_o,
    output logic [y86_core_pkg::WORD_W-1:0] pc_o,
    output logic [3:0]                       srca_o,
    output logic [3:0]                       srcb_o,
    output logic [3:0]                       dst_o,
    output logic [y86_core_pkg::WORD_W-1:0] wr_data_o,
    output logic                             wr_en_o,
    output logic                             exec_en_o,
    output logic [3:0]                       ex_icode_o,
    output logic [3:0]                       ex_ifun_o,
    output logic [y86_core_pkg::WORD_W-1:0] ex_vala_o,
    output logic [y86_core_pkg::WORD_W-1:0] ex_valb_o,
    output logic [y86_core_pkg::WORD_W-1:0] ex_valc_o,
    output logic                             halted_o,
    output logic [1:0]                       stat_o
);

    y86_core_pkg::state_e             state;
    logic [y86_core_pkg::WORD_W-1:0] pc_q, valp_q, vale_q, valm_q;
    logic [3:0]                       ra_q, rb_q;
    logic [y86_core_pkg::ADDR_W-1:0] fetch_adr;
    logic [1:0]                       stat_q;
    logic                             stb_q, cnd_q, is_mem, bad_adr, use_ra, use_rb;

    assign use_ra  = icode_i inside {y86_isa_pkg::I_RRMOVQ, y86_isa_pkg::I_RMMOVQ,
                                     y86_isa_pkg::I_OPQ};
    assign use_rb  = icode_i inside {y86_isa_pkg::I_RMMOVQ, y86_isa_pkg::I_MRMOVQ,
                                     y86_isa_pkg::I_OPQ};
    assign is_mem  = ex_icode_o inside {y86_isa_pkg::I_RMMOVQ, y86_isa_pkg::I_MRMOVQ};
    assign bad_adr = (vale_q[2:0] != 3'b000) || (|vale_q[y86_core_pkg::WORD_W-1:16]);

    // fetch always reads the aligned word holding pc, then the next one
    assign fetch_adr = {pc_q[y86_core_pkg::ADDR_W-1:3], 3'b000};

    assign wb.cyc   = stb_q;
    assign wb.stb   = stb_q;
    assign wb.we    = (state == y86_core_pkg::S_MEM) && (ex_icode_o == y86_isa_pkg::I_RMMOVQ);
    assign wb.dat_w = ex_vala_o;
    always_comb begin
        case (state)
            y86_core_pkg::S_FETCH0: wb.adr = fetch_adr;
            y86_core_pkg::S_FETCH1: wb.adr = fetch_adr + 16'd8;
            default:                wb.adr = vale_q[y86_core_pkg::ADDR_W-1:0];
        endcase
    end

    assign word0_ld_o = (state == y86_core_pkg::S_FETCH0) && stb_q && wb.ack;
    assign word1_ld_o = (state == y86_core_pkg::S_FETCH1) && stb_q && wb.ack;
    assign pc_o       = pc_q;
    assign srca_o     = use_ra ? ra_i : y86_isa_pkg::R_NONE;
    assign srcb_o     = use_rb ? rb_i : y86_isa_pkg::R_NONE;
    assign exec_en_o  = (state == y86_core_pkg::S_EXEC);
    assign wr_en_o    = (state == y86_core_pkg::S_WBACK);
    assign wr_data_o  = (ex_icode_o == y86_isa_pkg::I_MRMOVQ) ? valm_q : vale_q;
    assign halted_o   = (state == y86_core_pkg::S_HALT);
    assign stat_o     = stat_q;

    always_comb begin
        case (ex_icode_o)
            y86_isa_pkg::I_IRMOVQ, y86_isa_pkg::I_OPQ: dst_o = rb_q;
            y86_isa_pkg::I_RRMOVQ: dst_o = cnd_q ? rb_q : y86_isa_pkg::R_NONE;
            y86_isa_pkg::I_MRMOVQ: dst_o = ra_q;
            default:               dst_o = y86_isa_pkg::R_NONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state  <= y86_core_pkg::S_FETCH0;
            pc_q   <= '0;
            stb_q  <= 1'b0;
            stat_q <= y86_isa_pkg::STAT_AOK;
        end else begin
            case (state)
                y86_core_pkg::S_FETCH0, y86_core_pkg::S_FETCH1: begin
                    if (!stb_q) begin
                        stb_q <= 1'b1;
                    end else if (wb.ack) begin
                        stb_q <= 1'b0;
                        state <= (state == y86_core_pkg::S_FETCH0) ? y86_core_pkg::S_FETCH1
                                                                   : y86_core_pkg::S_DECODE;
                    end
                end
                y86_core_pkg::S_DECODE: begin
                    if (!instr_ok_i) begin
                        state  <= y86_core_pkg::S_HALT;
                        stat_q <= y86_isa_pkg::STAT_INS;
                    end else if (icode_i == y86_isa_pkg::I_HALT) begin
                        state  <= y86_core_pkg::S_HALT;
                        stat_q <= y86_isa_pkg::STAT_HLT;
                    end else begin
                        state <= y86_core_pkg::S_EXEC;
                    end
                end
                y86_core_pkg::S_EXEC:
                    state <= is_mem ? y86_core_pkg::S_MEM : y86_core_pkg::S_WBACK;
                y86_core_pkg::S_MEM: begin
                    if (!stb_q) begin
                        if (bad_adr) begin
                            state  <= y86_core_pkg::S_HALT;
                            stat_q <= y86_isa_pkg::STAT_ADR;
                        end else begin
                            stb_q <= 1'b1;
                        end
                    end else if (wb.ack) begin
                        stb_q <= 1'b0;
                        state <= y86_core_pkg::S_WBACK;
                    end
                end
                y86_core_pkg::S_WBACK: state <= y86_core_pkg::S_PCUPD;
                y86_core_pkg::S_PCUPD: begin
                    // taken jump goes to valC
                    pc_q  <= (ex_icode_o == y86_isa_pkg::I_JXX && cnd_q) ? ex_valc_o : valp_q;
                    state <= y86_core_pkg::S_FETCH0;
                end
                default: ; // S_HALT holds until reset
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == y86_core_pkg::S_DECODE) begin
            ex_icode_o <= icode_i;
            ex_ifun_o  <= ifun_i;
            ra_q       <= ra_i;
            rb_q       <= rb_i;
            ex_valc_o  <= valc_i;
            valp_q     <= valp_i;
            ex_vala_o  <= vala_i;
            ex_valb_o  <= valb_i;
        end
        if (state == y86_core_pkg::S_EXEC) begin
            vale_q <= vale_i;
            cnd_q  <= cnd_i;
        end
        if (state == y86_core_pkg::S_MEM && stb_q && wb.ack) begin
            valm_q <= wb.dat_r; // load data for mrmovq
        end
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [3:0]                       srca_i,
    input  logic [3:0]                       srcb_i,
    input  logic [3:0]                       dst_i,
    input  logic [y86_core_pkg::WORD_W-1:0] wr_data_i,
    input  logic                             wr_en_i,
    output logic [y86_core_pkg::WORD_W-1:0] vala_o,
    output logic [y86_core_pkg::WORD_W-1:0] valb_o
);

    logic [y86_core_pkg::WORD_W-1:0] regs [0:14]; // rax .. r14

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && dst_i != y86_isa_pkg::R_NONE) begin
            regs[dst_i] <= wr_data_i;
        end
    end

    assign vala_o = (srca_i == y86_isa_pkg::R_NONE) ? '0 : regs[srca_i];
    assign valb_o = (srcb_i == y86_isa_pkg::R_NONE) ? '0 : regs[srcb_i];

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             word0_ld_i,
    input  logic                             word1_ld_i,
    input  logic [y86_core_pkg::WORD_W-1:0] wb_dat_i,
    input  logic [y86_core_pkg::WORD_W-1:0] pc_i,
    output logic [3:0]                       icode_o,
    output logic [3:0]                       ifun_o,
    output logic [3:0]                       ra_o,
    output logic [3:0]                       rb_o,
    output logic [y86_core_pkg::WORD_W-1:0] valc_o,
    output logic [y86_core_pkg::WORD_W-1:0] valp_o,
    output logic                             instr_ok_o
);

    logic [y86_core_pkg::WORD_W-1:0]   word0, word1;
    logic [2*y86_core_pkg::WORD_W-1:0] shifted;
    y86_core_pkg::instr_u              instr;
    logic                              is_jxx, need_regs, need_valc;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            word0 <= '0;
            word1 <= '0;
        end else begin
            if (word0_ld_i) word0 <= wb_dat_i;
            if (word1_ld_i) word1 <= wb_dat_i;
        end
    end

    // drop the bytes below the pc offset
    assign shifted = {word1, word0} >> {pc_i[2:0], 3'b000};
    assign instr   = shifted[79:0];

    assign icode_o   = instr.reg_f.icode;
    assign ifun_o    = instr.reg_f.ifun;
    assign is_jxx    = (icode_o == y86_isa_pkg::I_JXX);
    assign ra_o      = is_jxx ? y86_isa_pkg::R_NONE : instr.reg_f.ra;
    assign rb_o      = is_jxx ? y86_isa_pkg::R_NONE : instr.reg_f.rb;
    assign valc_o    = is_jxx ? instr.jmp_f.dest : instr.reg_f.valc;
    assign instr_ok_o = (icode_o <= y86_isa_pkg::I_JXX);

    assign need_regs = icode_o inside {y86_isa_pkg::I_RRMOVQ, y86_isa_pkg::I_IRMOVQ,
                                       y86_isa_pkg::I_RMMOVQ, y86_isa_pkg::I_MRMOVQ,
                                       y86_isa_pkg::I_OPQ};
    assign need_valc = icode_o inside {y86_isa_pkg::I_IRMOVQ, y86_isa_pkg::I_RMMOVQ,
                                       y86_isa_pkg::I_MRMOVQ, y86_isa_pkg::I_JXX};

    // 1, 2, 9 or 10 bytes
    assign valp_o = pc_i + 64'd1 + {63'd0, need_regs} + {60'd0, need_valc, 3'b000};

endmodule

// File: execute/execute.sv
`timescale 1ns/100ps

module execute (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             exec_en_i,
    input  logic [3:0]                       icode_i,
    input  logic [3:0]                       ifun_i,
    input  logic [y86_core_pkg::WORD_W-1:0] vala_i,
    input  logic [y86_core_pkg::WORD_W-1:0] valb_i,
    input  logic [y86_core_pkg::WORD_W-1:0] valc_i,
    output logic [y86_core_pkg::WORD_W-1:0] vale_o,
    output logic                             cnd_o
);

    logic [y86_core_pkg::WORD_W-1:0] alu_a, alu_b;
    logic [3:0]                       alu_fun;
    y86_core_pkg::cc_t                cc_q, new_cc;
    logic                             lt;

    always_comb begin
        case (icode_i)
            y86_isa_pkg::I_RRMOVQ: begin
                alu_a = vala_i;
                alu_b = '0;
            end
            y86_isa_pkg::I_IRMOVQ: begin
                alu_a = valc_i;
                alu_b = '0;
            end
            y86_isa_pkg::I_RMMOVQ, y86_isa_pkg::I_MRMOVQ: begin
                alu_a = valc_i; // displacement plus base
                alu_b = valb_i;
            end
            y86_isa_pkg::I_OPQ: begin
                alu_a = vala_i;
                alu_b = valb_i;
            end
            default: begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    assign alu_fun = (icode_i == y86_isa_pkg::I_OPQ) ? ifun_i : y86_isa_pkg::ALU_ADD;

    always_comb begin
        case (alu_fun)
            y86_isa_pkg::ALU_SUB: vale_o = alu_b - alu_a;
            y86_isa_pkg::ALU_AND: vale_o = alu_a & alu_b;
            y86_isa_pkg::ALU_XOR: vale_o = alu_a ^ alu_b;
            default:              vale_o = alu_a + alu_b;
        endcase
    end

    always_comb begin
        new_cc.zf = (vale_o == '0);
        new_cc.sf = vale_o[63];
        case (alu_fun)
            y86_isa_pkg::ALU_ADD:
                new_cc.of = (alu_a[63] == alu_b[63]) && (vale_o[63] != alu_a[63]);
            y86_isa_pkg::ALU_SUB:
                new_cc.of = (alu_a[63] != alu_b[63]) && (vale_o[63] != alu_b[63]);
            default:
                new_cc.of = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cc_q <= '{zf: 1'b1, sf: 1'b0, of: 1'b0};
        end else if (exec_en_i && icode_i == y86_isa_pkg::I_OPQ) begin
            cc_q <= new_cc;
        end
    end

    assign lt = cc_q.sf ^ cc_q.of; // signed less than

    always_comb begin
        case (ifun_i)
            y86_isa_pkg::C_YES: cnd_o = 1'b1;
            y86_isa_pkg::C_LE:  cnd_o = lt | cc_q.zf;
            y86_isa_pkg::C_L:   cnd_o = lt;
            y86_isa_pkg::C_E:   cnd_o = cc_q.zf;
            y86_isa_pkg::C_NE:  cnd_o = !cc_q.zf;
            y86_isa_pkg::C_GE:  cnd_o = !lt;
            y86_isa_pkg::C_G:   cnd_o = !lt && !cc_q.zf;
            default:            cnd_o = 1'b0;
        endcase
    end

endmodule

// File: common/wb_if.sv
`timescale 1ns/100ps

interface wb_if;

    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [y86_core_pkg::ADDR_W-1:0] adr;
    logic [y86_core_pkg::WORD_W-1:0] dat_w; // master to slave
    logic [y86_core_pkg::WORD_W-1:0] dat_r; // slave to master
    logic                             ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: common/y86_core_pkg.sv
package y86_core_pkg;

    localparam int WORD_W = 64;
    localparam int ADDR_W = 16;

    typedef enum logic [2:0] {
        S_FETCH0,
        S_FETCH1,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WBACK,
        S_PCUPD,
        S_HALT
    } state_e;

    // byte 0 sits in the low bits, valC is little endian
    typedef union packed {
        struct packed {
            logic [63:0] valc;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  icode;
            logic [3:0]  ifun;
        } reg_f;
        struct packed {
            logic [7:0]  unused;
            logic [63:0] dest;
            logic [3:0]  icode;
            logic [3:0]  ifun;
        } jmp_f;
    } instr_u;

    typedef struct packed {
        logic zf;
        logic sf;
        logic of;
    } cc_t;

endpackage

// File: common/y86_isa_pkg.sv
package y86_isa_pkg;

    // instruction codes, standard Y86-64 encoding
    localparam logic [3:0] I_HALT   = 4'h0;
    localparam logic [3:0] I_NOP    = 4'h1;
    localparam logic [3:0] I_RRMOVQ = 4'h2; // also cmovXX
    localparam logic [3:0] I_IRMOVQ = 4'h3;
    localparam logic [3:0] I_RMMOVQ = 4'h4;
    localparam logic [3:0] I_MRMOVQ = 4'h5;
    localparam logic [3:0] I_OPQ    = 4'h6;
    localparam logic [3:0] I_JXX    = 4'h7;

    // ALU functions
    localparam logic [3:0] ALU_ADD = 4'h0;
    localparam logic [3:0] ALU_SUB = 4'h1;
    localparam logic [3:0] ALU_AND = 4'h2;
    localparam logic [3:0] ALU_XOR = 4'h3;

    // branch and move conditions
    localparam logic [3:0] C_YES = 4'h0;
    localparam logic [3:0] C_LE  = 4'h1;
    localparam logic [3:0] C_L   = 4'h2;
    localparam logic [3:0] C_E   = 4'h3;
    localparam logic [3:0] C_NE  = 4'h4;
    localparam logic [3:0] C_GE  = 4'h5;
    localparam logic [3:0] C_G   = 4'h6;

    localparam logic [3:0] R_NONE = 4'hf;

    // processor status
    localparam logic [1:0] STAT_AOK = 2'd0;
    localparam logic [1:0] STAT_HLT = 2'd1;
    localparam logic [1:0] STAT_ADR = 2'd2;
    localparam logic [1:0] STAT_INS = 2'd3;

endpackage
